// ==== compile.f ====
hw/soc_pkg.sv
hw/mem_bus_if.sv
hw/addr_decode.sv
hw/slave_xbar.sv
hw/bram.sv
hw/print_port.sv
hw/clint.sv
hw/soc_fabric.sv
verif/soc_checker.sv
verif/tb_soc.sv

// ==== hw/addr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module addr_decode #(
  parameter int bram_depth = 1024
) (
  input  logic                       valid_i,
  input  logic [soc_pkg::addr_w-1:0] addr_i,
  output soc_pkg::slave_sel_e        sel_o,
  output logic [soc_pkg::addr_w-1:0] rel_addr_o
);

  localparam logic [soc_pkg::addr_w-1:0] bram_top =
    soc_pkg::bram_base + soc_pkg::addr_w'(4 * bram_depth);

  logic [soc_pkg::addr_w-1:0] base;

  // Windows are checked CLINT first, then console, then RAM.
  always_comb begin
    sel_o = soc_pkg::sel_none;
    base  = '0;
    if (valid_i) begin
      if (addr_i >= soc_pkg::clint_base && addr_i < soc_pkg::clint_top) begin
        sel_o = soc_pkg::sel_clint;
        base  = soc_pkg::clint_base;
      end else if (addr_i >= soc_pkg::print_base && addr_i < soc_pkg::print_top) begin
        sel_o = soc_pkg::sel_print;
        base  = soc_pkg::print_base;
      end else if (addr_i >= soc_pkg::bram_base && addr_i < bram_top) begin
        sel_o = soc_pkg::sel_bram;
        base  = soc_pkg::bram_base;
      end
    end
  end

  assign rel_addr_o = addr_i - base;

endmodule

`default_nettype wire

// ==== hw/bram.sv ====
`timescale 1ns/100ps
`default_nettype none

module bram #(
  parameter int bram_depth = 1024
) (
  input  logic     clk,
  input  logic     rst,
  mem_bus_if.slave bus
);

  localparam int idx_w = $clog2(bram_depth);

  logic [soc_pkg::data_w-1:0] mem [bram_depth];
  logic [soc_pkg::data_w-1:0] rdata_q;
  logic                       ready_q;
  logic [idx_w-1:0]           idx;

  assign idx = bus.addr[idx_w+1:2]; // Word index.

  // The crossbar presents each request for one cycle only.
  always_ff @(posedge clk) begin
    if (bus.valid) begin
      for (int b = 0; b < soc_pkg::strb_w; b++) begin
        if (bus.wstrb[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[idx]; // Old word on a write.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus.valid;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;

endmodule

`default_nettype wire

// ==== hw/clint.sv ====
`timescale 1ns/100ps
`default_nettype none

module clint (
  input  logic     clk,
  input  logic     rst,
  mem_bus_if.slave bus,
  output logic     msip_o,
  output logic     mtip_o
);

  logic [63:0]                mtime_q;
  logic [63:0]                mtimecmp_q;
  logic                       msip_q;
  logic                       mtip_q;
  logic                       ready_q;
  logic [soc_pkg::data_w-1:0] rdata_q;
  logic                       wr;

  // Byte lanes of data replace those of old where the strobe is set.
  function automatic logic [soc_pkg::data_w-1:0] merge(
    input logic [soc_pkg::data_w-1:0] old,
    input logic [soc_pkg::data_w-1:0] data,
    input logic [soc_pkg::strb_w-1:0] strb
  );
    logic [soc_pkg::data_w-1:0] res;
    res = old;
    for (int b = 0; b < soc_pkg::strb_w; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr = bus.valid & (|bus.wstrb);

  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      mtip_q     <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      ready_q <= bus.valid;
      mtip_q  <= mtime_q >= mtimecmp_q;
      mtime_q <= mtime_q + 64'd1; // A write below takes precedence.
      if (wr) begin
        case (bus.addr)
          soc_pkg::clint_msip_off: begin
            if (bus.wstrb[0]) begin
              msip_q <= bus.wdata[0];
            end
          end
          soc_pkg::clint_mtimecmp_off:
            mtimecmp_q[31:0] <= merge(mtimecmp_q[31:0], bus.wdata, bus.wstrb);
          soc_pkg::clint_mtimecmp_off + 32'd4:
            mtimecmp_q[63:32] <= merge(mtimecmp_q[63:32], bus.wdata, bus.wstrb);
          soc_pkg::clint_mtime_off:
            mtime_q <= {mtime_q[63:32], merge(mtime_q[31:0], bus.wdata, bus.wstrb)};
          soc_pkg::clint_mtime_off + 32'd4:
            mtime_q <= {merge(mtime_q[63:32], bus.wdata, bus.wstrb), mtime_q[31:0]};
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.valid) begin
      case (bus.addr)
        soc_pkg::clint_msip_off:             rdata_q <= {31'b0, msip_q};
        soc_pkg::clint_mtimecmp_off:         rdata_q <= mtimecmp_q[31:0];
        soc_pkg::clint_mtimecmp_off + 32'd4: rdata_q <= mtimecmp_q[63:32];
        soc_pkg::clint_mtime_off:            rdata_q <= mtime_q[31:0];
        soc_pkg::clint_mtime_off + 32'd4:    rdata_q <= mtime_q[63:32];
        default:                             rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;
  assign msip_o    = msip_q;
  assign mtip_o    = mtip_q;

endmodule

`default_nettype wire

// ==== hw/mem_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;

  logic                        valid;
  logic                        instr;
  logic [soc_pkg::addr_w-1:0]  addr;
  logic [soc_pkg::data_w-1:0]  wdata;
  logic [soc_pkg::strb_w-1:0]  wstrb; // Zero means read.
  logic [soc_pkg::data_w-1:0]  rdata;
  logic                        ready; // One cycle pulse.

  modport master (
    output valid, instr, addr, wdata, wstrb,
    input  rdata, ready
  );

  modport slave (
    input  valid, instr, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

`default_nettype wire

// ==== hw/print_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module print_port (
  input  logic       clk,
  input  logic       rst,
  mem_bus_if.slave   bus,
  output logic [7:0] char_o,
  output logic       char_valid_o
);

  logic       ready_q;
  logic       char_valid_q;
  logic [7:0] char_q;
  logic       wr;

  assign wr = bus.valid & (|bus.wstrb);

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q      <= 1'b0;
      char_valid_q <= 1'b0;
    end else begin
      ready_q      <= bus.valid;
      char_valid_q <= wr; // Lines up with ready.
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      char_q <= bus.wdata[7:0];
    end
  end

  assign bus.rdata    = '0; // Reads give nothing back.
  assign bus.ready    = ready_q;
  assign char_o       = char_q;
  assign char_valid_o = char_valid_q;

endmodule

`default_nettype wire

// ==== hw/slave_xbar.sv ====
`timescale 1ns/100ps
`default_nettype none

module slave_xbar (
  input  logic                       clk,
  input  logic                       rst,
  input  soc_pkg::slave_sel_e        i_sel_i,
  input  soc_pkg::slave_sel_e        d_sel_i,
  input  logic [soc_pkg::addr_w-1:0] i_rel_addr_i,
  input  logic [soc_pkg::addr_w-1:0] d_rel_addr_i,
  mem_bus_if.slave                   imem,
  mem_bus_if.slave                   dmem,
  mem_bus_if.master                  bram_bus,
  mem_bus_if.master                  print_bus,
  mem_bus_if.master                  clint_bus
);

  // Bit 0 is the RAM, bit 1 the console, bit 2 the CLINT.
  logic [2:0] own_i_q;
  logic [2:0] own_d_q;
  logic       null_i_q;
  logic       null_d_q;
  logic       i_new;
  logic       d_new;
  logic [2:0] i_req;
  logic [2:0] d_req;
  logic [2:0] i_gnt;
  logic [2:0] rdy;

  function automatic logic [soc_pkg::data_w:0] route_resp(
    input logic [2:0]                 own,
    input logic [2:0]                 ready,
    input logic [soc_pkg::data_w-1:0] bram_rdata,
    input logic [soc_pkg::data_w-1:0] print_rdata,
    input logic [soc_pkg::data_w-1:0] clint_rdata
  );
    logic [soc_pkg::data_w:0] resp;
    resp = '0;
    if (own[0]) begin
      resp = {ready[0], bram_rdata};
    end else if (own[1]) begin
      resp = {ready[1], print_rdata};
    end else if (own[2]) begin
      resp = {ready[2], clint_rdata};
    end
    return resp;
  endfunction

  // While its response is on the way a master still holds valid.
  // That request was already issued.
  assign i_new = imem.valid & ~(|own_i_q) & ~null_i_q;
  assign d_new = dmem.valid & ~(|own_d_q) & ~null_d_q;

  assign i_req[0] = i_new & (i_sel_i == soc_pkg::sel_bram);
  assign i_req[1] = i_new & (i_sel_i == soc_pkg::sel_print);
  assign i_req[2] = i_new & (i_sel_i == soc_pkg::sel_clint);
  assign d_req[0] = d_new & (d_sel_i == soc_pkg::sel_bram);
  assign d_req[1] = d_new & (d_sel_i == soc_pkg::sel_print);
  assign d_req[2] = d_new & (d_sel_i == soc_pkg::sel_clint);

  assign i_gnt = i_req & ~d_req; // Data master wins a shared slave.

  assign bram_bus.valid = d_req[0] | i_gnt[0];
  assign bram_bus.instr = d_req[0] ? dmem.instr : imem.instr;
  assign bram_bus.addr  = d_req[0] ? d_rel_addr_i : i_rel_addr_i;
  assign bram_bus.wdata = d_req[0] ? dmem.wdata : imem.wdata;
  assign bram_bus.wstrb = d_req[0] ? dmem.wstrb : imem.wstrb;

  assign print_bus.valid = d_req[1] | i_gnt[1];
  assign print_bus.instr = d_req[1] ? dmem.instr : imem.instr;
  assign print_bus.addr  = d_req[1] ? d_rel_addr_i : i_rel_addr_i;
  assign print_bus.wdata = d_req[1] ? dmem.wdata : imem.wdata;
  assign print_bus.wstrb = d_req[1] ? dmem.wstrb : imem.wstrb;

  assign clint_bus.valid = d_req[2] | i_gnt[2];
  assign clint_bus.instr = d_req[2] ? dmem.instr : imem.instr;
  assign clint_bus.addr  = d_req[2] ? d_rel_addr_i : i_rel_addr_i;
  assign clint_bus.wdata = d_req[2] ? dmem.wdata : imem.wdata;
  assign clint_bus.wstrb = d_req[2] ? dmem.wstrb : imem.wstrb;

  // Owner of the response that arrives in the next cycle.
  always_ff @(posedge clk) begin
    if (!rst) begin
      own_i_q  <= '0;
      own_d_q  <= '0;
      null_i_q <= 1'b0;
      null_d_q <= 1'b0;
    end else begin
      own_i_q  <= i_gnt;
      own_d_q  <= d_req;
      null_i_q <= i_new & (i_sel_i == soc_pkg::sel_none); // Unmapped.
      null_d_q <= d_new & (d_sel_i == soc_pkg::sel_none);
    end
  end

  assign rdy = {clint_bus.ready, print_bus.ready, bram_bus.ready};

  assign {imem.ready, imem.rdata} = null_i_q ? {1'b1, {soc_pkg::data_w{1'b0}}} :
    route_resp(own_i_q, rdy, bram_bus.rdata, print_bus.rdata, clint_bus.rdata);
  assign {dmem.ready, dmem.rdata} = null_d_q ? {1'b1, {soc_pkg::data_w{1'b0}}} :
    route_resp(own_d_q, rdy, bram_bus.rdata, print_bus.rdata, clint_bus.rdata);

endmodule

`default_nettype wire

// ==== hw/soc_fabric.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_fabric #(
  parameter int bram_depth = 1024
) (
  input  logic                       clk,
  input  logic                       rst,
  // Instruction master.
  input  logic                       i_valid_i,
  input  logic                       i_instr_i,
  input  logic [soc_pkg::addr_w-1:0] i_addr_i,
  input  logic [soc_pkg::data_w-1:0] i_wdata_i,
  input  logic [soc_pkg::strb_w-1:0] i_wstrb_i,
  output logic [soc_pkg::data_w-1:0] i_rdata_o,
  output logic                       i_ready_o,
  // Data master.
  input  logic                       d_valid_i,
  input  logic                       d_instr_i,
  input  logic [soc_pkg::addr_w-1:0] d_addr_i,
  input  logic [soc_pkg::data_w-1:0] d_wdata_i,
  input  logic [soc_pkg::strb_w-1:0] d_wstrb_i,
  output logic [soc_pkg::data_w-1:0] d_rdata_o,
  output logic                       d_ready_o,
  output logic [7:0]                 char_o,
  output logic                       char_valid_o,
  output logic                       msip_o,
  output logic                       mtip_o
);

  soc_pkg::slave_sel_e        i_sel;
  soc_pkg::slave_sel_e        d_sel;
  logic [soc_pkg::addr_w-1:0] i_rel_addr;
  logic [soc_pkg::addr_w-1:0] d_rel_addr;

  mem_bus_if imem_bus ();
  mem_bus_if dmem_bus ();
  mem_bus_if bram_bus ();
  mem_bus_if print_bus ();
  mem_bus_if clint_bus ();

  assign imem_bus.valid = i_valid_i;
  assign imem_bus.instr = i_instr_i;
  assign imem_bus.addr  = i_addr_i;
  assign imem_bus.wdata = i_wdata_i;
  assign imem_bus.wstrb = i_wstrb_i;
  assign i_rdata_o      = imem_bus.rdata;
  assign i_ready_o      = imem_bus.ready;

  assign dmem_bus.valid = d_valid_i;
  assign dmem_bus.instr = d_instr_i;
  assign dmem_bus.addr  = d_addr_i;
  assign dmem_bus.wdata = d_wdata_i;
  assign dmem_bus.wstrb = d_wstrb_i;
  assign d_rdata_o      = dmem_bus.rdata;
  assign d_ready_o      = dmem_bus.ready;

  addr_decode #(.bram_depth(bram_depth)) i_decode (
    .valid_i    (i_valid_i),
    .addr_i     (i_addr_i),
    .sel_o      (i_sel),
    .rel_addr_o (i_rel_addr)
  );

  addr_decode #(.bram_depth(bram_depth)) d_decode (
    .valid_i    (d_valid_i),
    .addr_i     (d_addr_i),
    .sel_o      (d_sel),
    .rel_addr_o (d_rel_addr)
  );

  slave_xbar xbar (
    .clk          (clk),
    .rst          (rst),
    .i_sel_i      (i_sel),
    .d_sel_i      (d_sel),
    .i_rel_addr_i (i_rel_addr),
    .d_rel_addr_i (d_rel_addr),
    .imem         (imem_bus.slave),
    .dmem         (dmem_bus.slave),
    .bram_bus     (bram_bus.master),
    .print_bus    (print_bus.master),
    .clint_bus    (clint_bus.master)
  );

  bram #(.bram_depth(bram_depth)) ram (
    .clk (clk),
    .rst (rst),
    .bus (bram_bus.slave)
  );

  print_port console (
    .clk          (clk),
    .rst          (rst),
    .bus          (print_bus.slave),
    .char_o       (char_o),
    .char_valid_o (char_valid_o)
  );

  clint timer (
    .clk    (clk),
    .rst    (rst),
    .bus    (clint_bus.slave),
    .msip_o (msip_o),
    .mtip_o (mtip_o)
  );

endmodule

`default_nettype wire

// ==== hw/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // Bus widths.
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // Address map.
  localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;
  localparam logic [addr_w-1:0] clint_top  = 32'h0201_0000;
  localparam logic [addr_w-1:0] print_base = 32'h1000_0000;
  localparam logic [addr_w-1:0] print_top  = 32'h1000_1000;
  localparam logic [addr_w-1:0] bram_base  = 32'h8000_0000; // Top follows bram_depth.

  // CLINT register offsets. The 64-bit registers take the low word first.
  localparam logic [addr_w-1:0] clint_msip_off     = 32'h0000_0000;
  localparam logic [addr_w-1:0] clint_mtimecmp_off = 32'h0000_4000;
  localparam logic [addr_w-1:0] clint_mtime_off    = 32'h0000_BFF8;

  typedef enum logic [1:0] {
    sel_none  = 2'd0,
    sel_bram  = 2'd1,
    sel_print = 2'd2,
    sel_clint = 2'd3
  } slave_sel_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the fabric testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_soc -f compile.f
./obj_dir/Vtb_soc > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"

// ==== verif/soc_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_checker #(
  parameter int bram_depth = 1024
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_valid_i,
  input  logic        i_instr_i,
  input  logic [31:0] i_addr_i,
  input  logic [31:0] i_wdata_i,
  input  logic [3:0]  i_wstrb_i,
  input  logic [31:0] i_rdata_i,
  input  logic        i_ready_i,
  input  logic        d_valid_i,
  input  logic        d_instr_i,
  input  logic [31:0] d_addr_i,
  input  logic [31:0] d_wdata_i,
  input  logic [3:0]  d_wstrb_i,
  input  logic [31:0] d_rdata_i,
  input  logic        d_ready_i,
  input  logic [7:0]  char_i,
  input  logic        char_valid_i,
  input  logic        msip_i,
  input  logic        mtip_i,
  output int          errors_o
);

  localparam int idx_w = $clog2(bram_depth);
  localparam logic [31:0] ram_top = soc_pkg::bram_base + 32'(4 * bram_depth);
  localparam logic [31:0] mtime_addr = soc_pkg::clint_base + soc_pkg::clint_mtime_off;

  logic [31:0]           ram_m [bram_depth];
  logic [bram_depth-1:0] known_m; // Word fully written at least once.
  logic [63:0]           mtimecmp_m;
  logic                  msip_m;
  logic [31:0]           last_mtime;
  logic                  mtime_seen;
  logic                  char_hit;
  logic                  busy [2]; // Index 0 is the instruction port, 1 the data port.
  int                    waited [2];
  int                    lat_exp [2];
  logic [31:0]           req_addr [2];
  logic [31:0]           req_wdata [2];
  logic [3:0]            req_strb [2];
  int                    errors;

  task automatic flag_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
    $display("Error: %s expected %h got %h", sig, exp, got);
    errors = errors + 1;
  endtask

  task automatic flag_event(input string what);
    $display("%s", what);
    errors = errors + 1;
  endtask

  function automatic soc_pkg::slave_sel_e region(input logic [31:0] addr);
    if (addr >= soc_pkg::clint_base && addr < soc_pkg::clint_top) return soc_pkg::sel_clint;
    if (addr >= soc_pkg::print_base && addr < soc_pkg::print_top) return soc_pkg::sel_print;
    if (addr >= soc_pkg::bram_base && addr < ram_top) return soc_pkg::sel_bram;
    return soc_pkg::sel_none;
  endfunction

  // Expected read data, with bit 32 set when the value can be predicted.
  function automatic logic [32:0] ref_rdata(input logic [31:0] addr);
    logic [idx_w-1:0] idx;
    logic [31:0]      off;
    idx = addr[idx_w+1:2];
    off = addr - soc_pkg::clint_base;
    case (region(addr))
      soc_pkg::sel_bram: return {known_m[idx], ram_m[idx]};
      soc_pkg::sel_clint: begin
        case (off)
          soc_pkg::clint_msip_off:             return {1'b1, 31'b0, msip_m};
          soc_pkg::clint_mtimecmp_off:         return {1'b1, mtimecmp_m[31:0]};
          soc_pkg::clint_mtimecmp_off + 32'd4: return {1'b1, mtimecmp_m[63:32]};
          soc_pkg::clint_mtime_off:            return {1'b0, 32'h0}; // Free running.
          soc_pkg::clint_mtime_off + 32'd4:    return {1'b0, 32'h0};
          default:                             return {1'b1, 32'h0};
        endcase
      end
      default: return {1'b1, 32'h0}; // Console and unmapped space read zero.
    endcase
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [idx_w-1:0] idx;
    logic [31:0]      off;
    idx = addr[idx_w+1:2];
    off = addr - soc_pkg::clint_base;
    for (int b = 0; b < 4; b++) begin
      if (strb[b] && region(addr) == soc_pkg::sel_bram) ram_m[idx][8*b +: 8] = data[8*b +: 8];
      if (strb[b] && region(addr) == soc_pkg::sel_clint) begin
        if (off == soc_pkg::clint_mtimecmp_off) mtimecmp_m[8*b +: 8] = data[8*b +: 8];
        if (off == soc_pkg::clint_mtimecmp_off + 32'd4)
          mtimecmp_m[32+8*b +: 8] = data[8*b +: 8];
      end
    end
    if (region(addr) == soc_pkg::sel_bram && (&strb)) known_m[idx] = 1'b1;
    if (region(addr) == soc_pkg::sel_clint && off == soc_pkg::clint_msip_off && strb[0])
      msip_m = data[0];
  endtask

  task automatic step_port(input logic p, input logic contend);
    string       pn;
    logic        ready;
    logic [31:0] rdata;
    logic [32:0] exp;
    pn    = p ? "d" : "i";
    ready = p ? d_ready_i : i_ready_i;
    rdata = p ? d_rdata_i : i_rdata_i;
    if (busy[p]) begin
      waited[p] = waited[p] + 1;
      if (ready) begin
        busy[p] = 1'b0;
        if (waited[p] != lat_exp[p]) flag_value({pn, "_ready_o latency"}, lat_exp[p], waited[p]);
        if (!(|req_strb[p])) begin
          exp = ref_rdata(req_addr[p]);
          if (exp[32] && rdata !== exp[31:0]) flag_value({pn, "_rdata_o"}, exp[31:0], rdata);
          if (req_addr[p] == mtime_addr) begin
            if (mtime_seen && rdata <= last_mtime)
              flag_event($sformatf("Error: %s_rdata_o mtime %h not above %h", pn, rdata,
                                   last_mtime));
            last_mtime = rdata;
            mtime_seen = 1'b1;
          end
        end else begin
          if (region(req_addr[p]) == soc_pkg::sel_print) begin
            char_hit = 1'b1;
            if (!char_valid_i) flag_event("A console write gave no char_valid_o pulse");
            else if (char_i !== req_wdata[p][7:0])
              flag_value("char_o", {24'b0, req_wdata[p][7:0]}, {24'b0, char_i});
          end
          model_write(req_addr[p], req_wdata[p], req_strb[p]);
        end
      end
    end else if (p ? d_valid_i : i_valid_i) begin
      busy[p]      = 1'b1;
      waited[p]    = 0;
      lat_exp[p]   = contend ? 2 : 1; // Loser of arbitration waits one extra cycle.
      req_addr[p]  = p ? d_addr_i : i_addr_i;
      req_wdata[p] = p ? d_wdata_i : i_wdata_i;
      req_strb[p]  = p ? d_wstrb_i : i_wstrb_i;
    end else if (ready) begin
      flag_event({pn, "_ready_o rose with no request outstanding"});
    end
  endtask

  always @(posedge clk) begin : sample
    logic contend;
    if (!rst) begin
      busy[0]    = 1'b0;
      busy[1]    = 1'b0;
      known_m    = '0;
      msip_m     = 1'b0;
      mtimecmp_m = '1;
      mtime_seen = 1'b0;
      errors     = 0;
    end else begin
      contend = i_valid_i && !busy[0] && d_valid_i && !busy[1] &&
                region(i_addr_i) == region(d_addr_i) && region(i_addr_i) != soc_pkg::sel_none;
      char_hit = 1'b0;
      step_port(1'b1, 1'b0);
      step_port(1'b0, contend);
      if (char_valid_i && !char_hit) flag_event("char_valid_o pulsed without a console write");
      if (msip_i !== msip_m) flag_value("msip_o", {31'b0, msip_m}, {31'b0, msip_i});
      // A nonzero high compare word is out of reach of mtime.
      if (mtimecmp_m[63:32] != 32'h0 && mtip_i !== 1'b0)
        flag_value("mtip_o", 32'h0, {31'b0, mtip_i});
    end
  end

  assign errors_o = errors;

endmodule

`default_nettype wire

// ==== verif/tb_soc.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_soc;

  localparam int bram_depth = 1024;
  localparam logic [31:0] msip_addr = soc_pkg::clint_base + soc_pkg::clint_msip_off;
  localparam logic [31:0] cmp_addr  = soc_pkg::clint_base + soc_pkg::clint_mtimecmp_off;
  localparam logic [31:0] time_addr = soc_pkg::clint_base + soc_pkg::clint_mtime_off;

  logic        clk;
  logic        rst;
  logic        i_valid_i;
  logic        i_instr_i;
  logic [31:0] i_addr_i;
  logic [31:0] i_wdata_i;
  logic [3:0]  i_wstrb_i;
  logic [31:0] i_rdata_o;
  logic        i_ready_o;
  logic        d_valid_i;
  logic        d_instr_i;
  logic [31:0] d_addr_i;
  logic [31:0] d_wdata_i;
  logic [3:0]  d_wstrb_i;
  logic [31:0] d_rdata_o;
  logic        d_ready_o;
  logic [7:0]  char_o;
  logic        char_valid_o;
  logic        msip_o;
  logic        mtip_o;
  int          errors;
  int          n_pass;
  int          n_fail;
  int          err_mark;
  logic [31:0] rng;
  logic [31:0] r;
  logic [31:0] rd_i;
  logic [31:0] rd_d;
  logic [31:0] ram_addr [64];

  always #50 clk = ~clk;

  soc_fabric #(.bram_depth(bram_depth)) i_dut (.*);

  soc_checker #(.bram_depth(bram_depth)) i_chk (
    .clk (clk), .rst (rst),
    .i_valid_i (i_valid_i), .i_instr_i (i_instr_i), .i_addr_i (i_addr_i),
    .i_wdata_i (i_wdata_i), .i_wstrb_i (i_wstrb_i), .i_rdata_i (i_rdata_o),
    .i_ready_i (i_ready_o),
    .d_valid_i (d_valid_i), .d_instr_i (d_instr_i), .d_addr_i (d_addr_i),
    .d_wdata_i (d_wdata_i), .d_wstrb_i (d_wstrb_i), .d_rdata_i (d_rdata_o),
    .d_ready_i (d_ready_o),
    .char_i (char_o), .char_valid_i (char_valid_o), .msip_i (msip_o), .mtip_i (mtip_o),
    .errors_o (errors)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x   = rng;
    x   = x ^ (x << 13);
    x   = x ^ (x >> 17);
    x   = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("sim failed");
    $finish;
  endtask

  // One request on either port, held until ready, then one idle cycle.
  task automatic bus_access(input logic is_d, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata);
    logic got;
    got = 1'b0;
    if (is_d) begin
      {d_valid_i, d_instr_i, d_addr_i, d_wdata_i, d_wstrb_i} = {2'b10, addr, wdata, strb};
    end else begin
      {i_valid_i, i_instr_i, i_addr_i, i_wdata_i, i_wstrb_i} = {2'b11, addr, wdata, strb};
    end
    for (int n = 0; n < 50 && !got; n++) begin
      @(posedge clk);
      #10;
      got = is_d ? d_ready_o : i_ready_o;
    end
    rdata = is_d ? d_rdata_o : i_rdata_o;
    if (is_d) d_valid_i = 1'b0;
    else i_valid_i = 1'b0;
    if (!got && is_d) abort_run("no ready on the data port within 50 cycles");
    if (!got && !is_d) abort_run("no ready on the instruction port within 50 cycles");
    @(posedge clk);
    #10;
  endtask

  task automatic wait_mtip(input logic level);
    logic hit;
    hit = 1'b0;
    for (int n = 0; n < 50 && !hit; n++) begin
      @(posedge clk);
      #10;
      hit = (mtip_o == level);
    end
    if (!hit && level) abort_run("mtip_o did not rise within 50 cycles");
    if (!hit && !level) abort_run("mtip_o did not fall within 50 cycles");
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      n_pass = n_pass + 1;
      $display("PASS  %s", name);
    end else begin
      n_fail = n_fail + 1;
      $display("FAIL  %s (%0d errors)", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    {clk, rst, i_valid_i, i_instr_i, d_valid_i, d_instr_i} = '0;
    {i_addr_i, i_wdata_i, i_wstrb_i, d_addr_i, d_wdata_i, d_wstrb_i} = '0;
    {n_pass, n_fail, err_mark} = '0;
    rng = 32'd13661;
    repeat (10) @(posedge clk);
    #10;
    rst = 1'b1;
    @(posedge clk);
    #10;

    for (int k = 0; k < 64; k++) begin
      ram_addr[k] = soc_pkg::bram_base + ((next_rand() % bram_depth) << 2);
      bus_access(1'b1, ram_addr[k], next_rand(), 4'hf, rd_d);
      r = next_rand();
      bus_access(1'b1, ram_addr[k], next_rand(), (r[3:0] == 4'h0) ? 4'h6 : r[3:0], rd_d);
      bus_access(1'b1, ram_addr[k], '0, 4'h0, rd_d);
    end
    end_test("RAM write and read back on the data port");

    for (int k = 0; k < 8; k++) begin
      fork
        bus_access(1'b0, ram_addr[k], '0, 4'h0, rd_i);
        bus_access(1'b1, cmp_addr, '0, 4'h0, rd_d);
      join
    end
    end_test("Fetch from RAM while the data port reads the CLINT");

    for (int k = 0; k < 8; k++) begin
      fork
        bus_access(1'b0, ram_addr[k+8], '0, 4'h0, rd_i);
        bus_access(1'b1, ram_addr[k+16], '0, 4'h0, rd_d);
      join
    end
    end_test("Both ports to the RAM in the same cycle");

    for (int k = 0; k < 8; k++) begin
      r = next_rand() & 32'h0000_0ffc;
      bus_access(1'b1, soc_pkg::print_base + r, next_rand(), 4'h1, rd_d);
    end
    end_test("Console writes");

    bus_access(1'b1, msip_addr, 32'h1, 4'hf, rd_d);
    bus_access(1'b1, msip_addr, 32'h0, 4'hf, rd_d);
    r = next_rand();
    bus_access(1'b1, cmp_addr, r, 4'hf, rd_d);
    bus_access(1'b1, cmp_addr + 32'd4, r | 32'h8000_0000, 4'hf, rd_d);
    bus_access(1'b1, cmp_addr, '0, 4'h0, rd_d);
    bus_access(1'b1, cmp_addr + 32'd4, '0, 4'h0, rd_d);
    bus_access(1'b1, time_addr, '0, 4'h0, rd_d);
    bus_access(1'b1, cmp_addr, rd_d + 32'd30, 4'hf, rd_d); // Just ahead of mtime.
    bus_access(1'b1, cmp_addr + 32'd4, 32'h0, 4'hf, rd_d);
    wait_mtip(1'b1);
    bus_access(1'b1, cmp_addr, '1, 4'hf, rd_d);
    bus_access(1'b1, cmp_addr + 32'd4, '1, 4'hf, rd_d);
    wait_mtip(1'b0);
    bus_access(1'b1, time_addr, '0, 4'h0, rd_d);
    end_test("CLINT registers and interrupts");

    fork
      bus_access(1'b0, 32'h4000_0000, '0, 4'h0, rd_i);
      bus_access(1'b1, 32'h4000_0000, '0, 4'h0, rd_d);
    join
    end_test("Unmapped reads on both ports");

    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
